/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := tb_tank_video
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+100000
LOG       := sim.log
FAIL_MSG  := Some tests failed

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
src/tank_video_pkg.sv
src/vga_timing.sv
src/sprite_regs.sv
src/tank_sprite.sv
src/bullet_marker.sv
src/pixel_compositor.sv
src/tank_video_top.sv
tb/tb_tank_video_assert.sv
tb/tb_tank_video.sv

/* src/bullet_marker.sv */
/*
 * Bullet marker stage: 9x9 square around the bullet centre
 */
`timescale 1ns/100ps

module bullet_marker (
    input  logic                          clk,
    input  logic                          reset,
    input  tank_video_pkg::pixel_pos_t    pos,
    input  tank_video_pkg::bullet_state_t bullet,
    output logic                          hit
);

    tank_video_pkg::coord_t dist_x;
    tank_video_pkg::coord_t dist_y;
    logic                   hit_q;

    assign dist_x = (pos.x > bullet.x) ? pos.x - bullet.x : bullet.x - pos.x;
    assign dist_y = (pos.y > bullet.y) ? pos.y - bullet.y : bullet.y - pos.y;

    // Second stage matches the tank ROM read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_q <= 1'b0;
            hit   <= 1'b0;
        end else begin
            hit_q <= bullet.on && dist_x < tank_video_pkg::BULLET_RADIUS &&
                     dist_y < tank_video_pkg::BULLET_RADIUS;
            hit   <= hit_q;
        end
    end

endmodule

/* src/pixel_compositor.sv */
/*
 * Pixel compositor: sync delay line, palette lookup,
 * layer priority and the output register for the VGA pins
 */
`timescale 1ns/100ps

module pixel_compositor (
    input  logic                      clk,
    input  logic                      reset,
    input  tank_video_pkg::vga_sync_t sync_in,
    input  logic                      tank1_hit,
    input  logic                      tank2_hit,
    input  logic                      bullet1_hit,
    input  logic                      bullet2_hit,
    input  logic [7:0]                tank1_data,
    input  logic [7:0]                tank2_data,
    output tank_video_pkg::rgb_t      rgb,
    output tank_video_pkg::vga_sync_t sync_out
);

    // Syncs inactive, picture blanked
    localparam tank_video_pkg::vga_sync_t SYNC_IDLE = '{
        hs: 1'b1,
        vs: 1'b1,
        blank_n: 1'b0,
        vga_clk: 1'b0
    };

    tank_video_pkg::vga_sync_t sync_d1;
    tank_video_pkg::vga_sync_t sync_d2;
    tank_video_pkg::rgb_t      rgb_next;

    // Tank 1 on top, bullet 2 at the bottom
    always_comb begin
        rgb_next = '0;
        if (sync_d2.blank_n) begin
            if (tank1_hit) begin
                rgb_next = tank_video_pkg::palette_rgb(tank1_data);
            end else if (tank2_hit) begin
                rgb_next = tank_video_pkg::palette_rgb(tank2_data);
            end else if (bullet1_hit) begin
                rgb_next = tank_video_pkg::P1_BULLET_RGB;
            end else if (bullet2_hit) begin
                rgb_next = tank_video_pkg::P2_BULLET_RGB;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_d1  <= SYNC_IDLE;
            sync_d2  <= SYNC_IDLE;
            sync_out <= SYNC_IDLE;
            rgb      <= '0;
        end else begin
            sync_d1  <= sync_in;
            sync_d2  <= sync_d1;
            sync_out <= sync_d2;
            rgb      <= rgb_next;
        end
    end

endmodule

/* src/sprite_regs.sv */
/*
 * Write-only register bank for tank and bullet state,
 * unpacked and scaled to screen coordinates
 */
`timescale 1ns/100ps

module sprite_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          chipselect,
    input  logic                          write,
    input  logic [3:0]                    address,
    input  logic [15:0]                   writedata,
    output tank_video_pkg::tank_state_t   p1_tank,
    output tank_video_pkg::tank_state_t   p2_tank,
    output tank_video_pkg::bullet_state_t p1_bullet,
    output tank_video_pkg::bullet_state_t p2_bullet
);

    logic [15:0] p1_tank_loc;
    logic [15:0] p2_tank_loc;
    logic [15:0] p1_bullet_loc;
    logic [15:0] p2_bullet_loc;
    logic [1:0]  p1_tank_dir;
    logic [1:0]  p2_tank_dir;
    logic        p1_bullet_on;
    logic        p2_bullet_on;

    // Location bytes are in units of 4 pixels
    function automatic tank_video_pkg::coord_t scale(input logic [7:0] b);
        return tank_video_pkg::coord_t'(b) << tank_video_pkg::POS_SCALE_SHIFT;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p1_tank_loc   <= '0;
            p2_tank_loc   <= '0;
            p1_bullet_loc <= '0;
            p2_bullet_loc <= '0;
            p1_tank_dir   <= '0;
            p2_tank_dir   <= '0;
            p1_bullet_on  <= 1'b0;
            p2_bullet_on  <= 1'b0;
        end else if (chipselect && write) begin
            case (address)
                tank_video_pkg::ADDR_P1_TANKL:   p1_tank_loc   <= writedata;
                tank_video_pkg::ADDR_P1_TANKD:   p1_tank_dir   <= writedata[15:14];
                tank_video_pkg::ADDR_P2_TANKL:   p2_tank_loc   <= writedata;
                tank_video_pkg::ADDR_P2_TANKD:   p2_tank_dir   <= writedata[15:14];
                tank_video_pkg::ADDR_P1_BULLETL: p1_bullet_loc <= writedata;
                tank_video_pkg::ADDR_P1_BULLETD: p1_bullet_on  <= writedata[15];
                tank_video_pkg::ADDR_P2_BULLETL: p2_bullet_loc <= writedata;
                tank_video_pkg::ADDR_P2_BULLETD: p2_bullet_on  <= writedata[15];
                default: ;
            endcase
        end
    end

    always_comb begin
        p1_tank   = '{x: scale(p1_tank_loc[15:8]), y: scale(p1_tank_loc[7:0]), dir: p1_tank_dir};
        p2_tank   = '{x: scale(p2_tank_loc[15:8]), y: scale(p2_tank_loc[7:0]), dir: p2_tank_dir};
        p1_bullet = '{x: scale(p1_bullet_loc[15:8]), y: scale(p1_bullet_loc[7:0]),
                      on: p1_bullet_on};
        p2_bullet = '{x: scale(p2_bullet_loc[15:8]), y: scale(p2_bullet_loc[7:0]),
                      on: p2_bullet_on};
    end

endmodule

/* src/tank_sprite.sv */
/*
 * Tank sprite stage: 32x32 box test and sprite ROM address,
 * hit delayed to line up with the ROM data
 */
`timescale 1ns/100ps

module tank_sprite (
    input  logic                           clk,
    input  logic                           reset,
    input  tank_video_pkg::pixel_pos_t     pos,
    input  tank_video_pkg::tank_state_t    tank,
    output logic                           hit,
    output tank_video_pkg::tank_rom_addr_t rom_addr
);

    tank_video_pkg::coord_t dx;
    tank_video_pkg::coord_t dy;
    logic                   in_box;
    logic                   hit_q;

    assign dx = pos.x - tank.x;
    assign dy = pos.y - tank.y;

    // Offsets are only meaningful once the pixel is right of and below the corner
    assign in_box = pos.x >= tank.x && dx < tank_video_pkg::SPRITE_SIZE &&
                    pos.y >= tank.y && dy < tank_video_pkg::SPRITE_SIZE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_q <= 1'b0;
            hit   <= 1'b0;
        end else begin
            hit_q <= in_box;
            hit   <= hit_q;
        end
    end

    // One ROM frame per heading
    always_ff @(posedge clk) begin
        if (in_box) begin
            rom_addr <= tank_video_pkg::tank_rom_addr_t'(
                dx + dy * tank_video_pkg::SPRITE_SIZE +
                tank.dir * tank_video_pkg::SPRITE_FRAME_WORDS);
        end
    end

endmodule

/* src/tank_video_pkg.sv */
/*
 * Shared types for the tank video peripheral: colour, sync, pixel position,
 * tank and bullet state, register map, sprite geometry and the game palette
 */
package tank_video_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [11:0] tank_rom_addr_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // All active low except vga_clk
    typedef struct packed {
        logic hs;
        logic vs;
        logic blank_n;
        logic vga_clk;
    } vga_sync_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    // Heading codes 0 up, 1 down, 2 left, 3 right
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [1:0] dir;
    } tank_state_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   on;
    } bullet_state_t;

    localparam logic [3:0] ADDR_P1_TANKL   = 4'd2;
    localparam logic [3:0] ADDR_P1_TANKD   = 4'd3;
    localparam logic [3:0] ADDR_P2_TANKL   = 4'd4;
    localparam logic [3:0] ADDR_P2_TANKD   = 4'd5;
    localparam logic [3:0] ADDR_P1_BULLETL = 4'd6;
    localparam logic [3:0] ADDR_P1_BULLETD = 4'd7;
    localparam logic [3:0] ADDR_P2_BULLETL = 4'd8;
    localparam logic [3:0] ADDR_P2_BULLETD = 4'd9;

    localparam int POS_SCALE_SHIFT    = 2;
    localparam int SPRITE_SIZE        = 32;
    localparam int SPRITE_FRAME_WORDS = 1024;
    localparam int BULLET_RADIUS      = 5;

    localparam rgb_t P1_BULLET_RGB = '{r: 8'hff, g: 8'hf6, b: 8'h33};
    localparam rgb_t P2_BULLET_RGB = '{r: 8'hd8, g: 8'hd8, b: 8'hd8};

    function automatic rgb_t palette_rgb(input logic [7:0] index);
        rgb_t c;
        case (index)
            8'h00: c = {8'hf0, 8'hf0, 8'hf0};
            8'h01: c = {8'hb0, 8'ha0, 8'ha0};
            8'h02: c = {8'ha0, 8'ha0, 8'hb0};
            8'h03: c = {8'ha0, 8'ha0, 8'ha0};
            8'h04: c = {8'hb0, 8'h30, 8'h20};
            8'h05: c = {8'hb0, 8'h20, 8'h20};
            8'h06: c = {8'he0, 8'he0, 8'h90};
            8'h07: c = {8'he0, 8'h90, 8'h20};
            8'h08: c = {8'he0, 8'h90, 8'h10};
            8'h09: c = {8'h90, 8'h40, 8'h00};
            8'h0a: c = {8'h60, 8'h60, 8'h60};
            8'h0b: c = {8'h60, 8'h60, 8'h00};
            8'h0c: c = {8'h60, 8'h00, 8'h00};
            8'h0d: c = {8'h50, 8'h00, 8'h70};
            8'h0e: c = {8'h00, 8'h40, 8'h40};
            // Entry 15 and anything past the table is black
            default: c = '0;
        endcase
        return c;
    endfunction

endpackage

/* src/tank_video_top.sv */
/*
 * Tank game video peripheral top level: register port, VGA timing,
 * two tank sprite stages, two bullet markers and the compositor
 */
`timescale 1ns/100ps

module tank_video_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 32,
    parameter int H_SYNC   = 192,
    parameter int H_BACK   = 96,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           chipselect,
    input  logic                           write,
    input  logic [3:0]                     address,
    input  logic [15:0]                    writedata,
    input  logic [7:0]                     tank1_rom_data,
    input  logic [7:0]                     tank2_rom_data,
    output tank_video_pkg::tank_rom_addr_t tank1_rom_addr,
    output tank_video_pkg::tank_rom_addr_t tank2_rom_addr,
    output logic [7:0]                     vga_r,
    output logic [7:0]                     vga_g,
    output logic [7:0]                     vga_b,
    output logic                           vga_clk,
    output logic                           vga_hs,
    output logic                           vga_vs,
    output logic                           vga_blank_n
);

    tank_video_pkg::pixel_pos_t    pos;
    tank_video_pkg::vga_sync_t     sync;
    tank_video_pkg::vga_sync_t     pin_sync;
    tank_video_pkg::rgb_t          pin_rgb;
    tank_video_pkg::tank_state_t   p1_tank;
    tank_video_pkg::tank_state_t   p2_tank;
    tank_video_pkg::bullet_state_t p1_bullet;
    tank_video_pkg::bullet_state_t p2_bullet;
    logic                          tank1_hit;
    logic                          tank2_hit;
    logic                          bullet1_hit;
    logic                          bullet2_hit;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_vga_timing (
        .clk(clk), .reset(reset), .pos(pos), .sync(sync)
    );

    sprite_regs i_sprite_regs (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata),
        .p1_tank(p1_tank), .p2_tank(p2_tank),
        .p1_bullet(p1_bullet), .p2_bullet(p2_bullet)
    );

    tank_sprite i_tank1_sprite (
        .clk(clk), .reset(reset), .pos(pos), .tank(p1_tank),
        .hit(tank1_hit), .rom_addr(tank1_rom_addr)
    );

    tank_sprite i_tank2_sprite (
        .clk(clk), .reset(reset), .pos(pos), .tank(p2_tank),
        .hit(tank2_hit), .rom_addr(tank2_rom_addr)
    );

    bullet_marker i_bullet1_marker (
        .clk(clk), .reset(reset), .pos(pos), .bullet(p1_bullet), .hit(bullet1_hit)
    );

    bullet_marker i_bullet2_marker (
        .clk(clk), .reset(reset), .pos(pos), .bullet(p2_bullet), .hit(bullet2_hit)
    );

    pixel_compositor i_pixel_compositor (
        .clk(clk), .reset(reset), .sync_in(sync),
        .tank1_hit(tank1_hit), .tank2_hit(tank2_hit),
        .bullet1_hit(bullet1_hit), .bullet2_hit(bullet2_hit),
        .tank1_data(tank1_rom_data), .tank2_data(tank2_rom_data),
        .rgb(pin_rgb), .sync_out(pin_sync)
    );

    assign vga_r       = pin_rgb.r;
    assign vga_g       = pin_rgb.g;
    assign vga_b       = pin_rgb.b;
    assign vga_clk     = pin_sync.vga_clk;
    assign vga_hs      = pin_sync.hs;
    assign vga_vs      = pin_sync.vs;
    assign vga_blank_n = pin_sync.blank_n;

endmodule

/* src/vga_timing.sv */
/*
 * VGA timing generator: horizontal and vertical counters,
 * sync and blank decode, pixel position (one pixel per two clocks)
 */
`timescale 1ns/100ps

module vga_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 32,
    parameter int H_SYNC   = 192,
    parameter int H_BACK   = 96,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                       clk,
    input  logic                       reset,
    output tank_video_pkg::pixel_pos_t pos,
    output tank_video_pkg::vga_sync_t  sync
);

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_W      = $clog2(H_TOTAL);
    localparam int V_W      = $clog2(V_TOTAL);
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [H_W-1:0] hcount;
    logic [V_W-1:0] vcount;
    logic           end_of_line;
    logic           end_of_frame;

    assign end_of_line  = hcount == H_TOTAL - 1;
    assign end_of_frame = vcount == V_TOTAL - 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_frame ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Pixel column advances every second clock
    assign pos.x = tank_video_pkg::coord_t'(hcount >> 1);
    assign pos.y = tank_video_pkg::coord_t'(vcount);

    always_comb begin
        sync.hs      = !(hcount >= HS_START && hcount < HS_END);
        sync.vs      = !(vcount >= VS_START && vcount < VS_END);
        sync.blank_n = hcount < H_ACTIVE && vcount < V_ACTIVE;
        sync.vga_clk = hcount[0];
    end

endmodule

/* tb/tb_tank_video.sv */
/*
 * Testbench for the tank video top level: clock and reset, random register
 * writes, sprite ROM model, pixel reference model with pin checks, watchdog
 */
`timescale 1ns/100ps

module tb_tank_video;

    localparam int CLK_PERIOD   = 20;
    localparam int SEED         = 43895;
    localparam int FRAME_CLOCKS = 1600 * 525;
    localparam int RUN_CLOCKS   = 2 * FRAME_CLOCKS;
    localparam int TIMEOUT_NS   = 3 * FRAME_CLOCKS * CLK_PERIOD;

    typedef struct packed {
        tank_video_pkg::rgb_t      rgb;
        tank_video_pkg::vga_sync_t sync;
    } pins_t;

    localparam pins_t IDLE_PINS = '{rgb: 24'h0,
        sync: '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, vga_clk: 1'b0}};

    // Game palette with entry 15 black
    localparam logic [23:0] PALETTE [16] = '{
        24'hf0f0f0, 24'hb0a0a0, 24'ha0a0b0, 24'ha0a0a0,
        24'hb03020, 24'hb02020, 24'he0e090, 24'he09020,
        24'he09010, 24'h904000, 24'h606060, 24'h606000,
        24'h600000, 24'h500070, 24'h004040, 24'h000000
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [3:0]  address;
    logic [15:0] writedata;
    logic [7:0]  rom_data [2] = '{8'h00, 8'h00};
    logic [11:0] rom_addr [2];
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;

    // Reference model state
    int          h;
    int          v;
    int          tank_x [2];
    int          tank_y [2];
    int          tank_dir [2];
    int          bullet_x [2];
    int          bullet_y [2];
    bit          bullet_on [2];
    bit          addr_due [2];
    logic [11:0] addr_expected [2];
    pins_t       history [3];
    int          checks = 0;
    int          errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tank_video_top i_tank_video_top (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata),
        .tank1_rom_data(rom_data[0]), .tank2_rom_data(rom_data[1]),
        .tank1_rom_addr(rom_addr[0]), .tank2_rom_addr(rom_addr[1]),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_clk(vga_clk),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n)
    );

    // Synchronous sprite ROM whose words hold their low five address bits
    always @(posedge clk) begin
        rom_data[0] <= {3'b000, rom_addr[0][4:0]};
        rom_data[1] <= {3'b000, rom_addr[1][4:0]};
    end

    function automatic bit in_tank(input int i, input int x, input int y);
        return x >= tank_x[i] && x < tank_x[i] + 32 &&
               y >= tank_y[i] && y < tank_y[i] + 32;
    endfunction

    function automatic bit in_bullet(input int i, input int x, input int y);
        int dx;
        int dy;
        dx = x > bullet_x[i] ? x - bullet_x[i] : bullet_x[i] - x;
        dy = y > bullet_y[i] ? y - bullet_y[i] : bullet_y[i] - y;
        return bullet_on[i] && dx < 5 && dy < 5;
    endfunction

    function automatic logic [11:0] rom_address(input int i, input int x, input int y);
        return 12'((x - tank_x[i]) + 32 * (y - tank_y[i]) + 1024 * tank_dir[i]);
    endfunction

    // ROM word is the column offset, so the index runs 0 to 31
    function automatic logic [23:0] tank_colour(input int i, input int x);
        int index;
        index = x - tank_x[i];
        return index < 16 ? PALETTE[index] : 24'h0;
    endfunction

    function automatic pins_t expected_pins();
        pins_t p;
        int    x;
        x = h / 2;
        p.sync.hs = !(h >= 1312 && h < 1504);
        p.sync.vs = !(v >= 490 && v < 492);
        p.sync.blank_n = h < 1280 && v < 480;
        p.sync.vga_clk = h % 2;
        p.rgb = '0;
        if (p.sync.blank_n) begin
            if (in_tank(0, x, v)) begin
                p.rgb = tank_colour(0, x);
            end else if (in_tank(1, x, v)) begin
                p.rgb = tank_colour(1, x);
            end else if (in_bullet(0, x, v)) begin
                p.rgb = 24'hfff633;
            end else if (in_bullet(1, x, v)) begin
                p.rgb = 24'hd8d8d8;
            end
        end
        return p;
    endfunction

    // Player index is address bit 2 for tanks and bit 3 for bullets
    task automatic apply_write(input logic [3:0] a, input logic [15:0] d);
        case (a)
            4'd2, 4'd4: begin
                tank_x[a[2]] = d[15:8] * 4;
                tank_y[a[2]] = d[7:0] * 4;
            end
            4'd3, 4'd5: tank_dir[a[2]] = d[15:14];
            4'd6, 4'd8: begin
                bullet_x[a[3]] = d[15:8] * 4;
                bullet_y[a[3]] = d[7:0] * 4;
            end
            4'd7, 4'd9: bullet_on[a[3]] = d[15];
            default: ;
        endcase
    endtask

    task automatic reset_model();
        h = 0;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            tank_x[i] = 0;
            tank_y[i] = 0;
            tank_dir[i] = 0;
            bullet_x[i] = 0;
            bullet_y[i] = 0;
            bullet_on[i] = 1'b0;
            addr_due[i] = 1'b0;
        end
        history = '{IDLE_PINS, IDLE_PINS, IDLE_PINS};
    endtask

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic check_pins(input pins_t e);
        check_value("vga_r", e.rgb.r, vga_r);
        check_value("vga_g", e.rgb.g, vga_g);
        check_value("vga_b", e.rgb.b, vga_b);
        check_value("vga_hs", e.sync.hs, vga_hs);
        check_value("vga_vs", e.sync.vs, vga_vs);
        check_value("vga_blank_n", e.sync.blank_n, vga_blank_n);
        check_value("vga_clk", e.sync.vga_clk, vga_clk);
    endtask

    task automatic random_write();
        logic [3:0]  a;
        logic [15:0] d;
        if ($urandom % 2000 == 0) begin
            a = 4'($urandom % 16);
            d = 16'($urandom);
            if (a == 4'd7 || a == 4'd9) begin
                d[15] = ($urandom % 4) != 0;
            end
            chipselect <= 1'b1;
            write <= 1'b1;
            address <= a;
            writedata <= d;
        end else begin
            chipselect <= 1'b0;
            write <= 1'b0;
        end
    endtask

    // Pins are sampled at the falling edge and trail the counters by three clocks
    always @(negedge clk) begin
        if (reset) begin
            reset_model();
            check_pins(IDLE_PINS);
        end else begin
            check_pins(history[2]);
            for (int i = 0; i < 2; i++) begin
                if (addr_due[i]) begin
                    check_value($sformatf("tank%0d_rom_addr", i + 1), addr_expected[i],
                                rom_addr[i]);
                end
                addr_due[i] = in_tank(i, h / 2, v);
                addr_expected[i] = rom_address(i, h / 2, v);
            end
            history[2] = history[1];
            history[1] = history[0];
            history[0] = expected_pins();
            if (chipselect && write) begin
                apply_write(address, writedata);
            end
            h = (h + 1) % 1600;
            if (h == 0) begin
                v = (v + 1) % 525;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = 4'h0;
        writedata = 16'h0000;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (RUN_CLOCKS) begin
            @(posedge clk);
            random_write();
        end
        @(posedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 i_tank_video_top.i_tank_video_assert.fail_count);
        if (errors == 0 && i_tank_video_top.i_tank_video_assert.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog at three frames
    initial begin
        #(TIMEOUT_NS);
        $display("Error: run timed out after %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* tb/tb_tank_video_assert.sv */
/*
 * Concurrent assertions on the VGA pins of the tank video top level
 */
`timescale 1ns/100ps

module tb_tank_video_assert (
    input logic       clk,
    input logic       reset,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b,
    input logic       vga_clk,
    input logic       vga_hs,
    input logic       vga_vs,
    input logic       vga_blank_n
);

    logic [2:0] cycles;
    // Number of failed assertions
    int         fail_count = 0;

    // Live timing reaches the pins on the fourth clock after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles <= '0;
        end else if (cycles != 3'd7) begin
            cycles <= cycles + 1'b1;
        end
    end

    blank_is_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> {vga_r, vga_g, vga_b} == 24'h0)
        else begin
            $error("colour not black while blanked");
            fail_count++;
        end

    clk_toggles: assert property (@(posedge clk) disable iff (reset)
        cycles >= 3'd4 |-> vga_clk != $past(vga_clk))
        else begin
            $error("vga_clk held its value for two clocks");
            fail_count++;
        end

    no_sync_in_active: assert property (@(posedge clk) disable iff (reset)
        vga_blank_n |-> vga_hs && vga_vs)
        else begin
            $error("sync pulse during active video");
            fail_count++;
        end

endmodule

bind tank_video_top tb_tank_video_assert i_tank_video_assert (
    .clk(clk), .reset(reset), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
    .vga_clk(vga_clk), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n)
);
